// ==== common/pmu_config.svh ====
// Sizes and register map of the performance monitoring unit.
// Include this header wherever a width or a register index is needed.
// The register index is the word address, taken from HADDR bits 5:2.

`ifndef PMU_CONFIG_SVH
`define PMU_CONFIG_SVH

// Sizes
`define PMU_N_COUNTERS     4
`define PMU_N_EVENTS       32
`define PMU_REG_WIDTH      32
`define PMU_ADDR_WIDTH     32
`define PMU_IDX_WIDTH      4
`define PMU_SEL_WIDTH      5

// Register map, in word indexes
`define PMU_REG_CTRL       0
`define PMU_REG_CNT_BASE   1
`define PMU_REG_OVF_STATUS 5
`define PMU_REG_OVF_MASK   6
`define PMU_REG_SEL_BASE   7
`define PMU_N_REGS         11

// Control register fields
`define PMU_CTRL_EN_BIT    0
`define PMU_CTRL_CLR_BIT   1

`endif

// ==== common/pmu_pkg.sv ====
// Shared types of the performance monitoring unit.
// Modules refer to these types by scoped names; widths come from the
// configuration header.

`include "pmu_config.svh"

package pmu_pkg;

    // One register or bus data word
    typedef logic [`PMU_REG_WIDTH-1:0] reg_word_t;

    // Word index into the register bank
    typedef logic [`PMU_IDX_WIDTH-1:0] reg_idx_t;

    // Raw system event inputs
    typedef logic [`PMU_N_EVENTS-1:0] events_t;

    // Event number picked by one counter
    typedef logic [`PMU_SEL_WIDTH-1:0] event_sel_t;

    // One flag per counter
    typedef logic [`PMU_N_COUNTERS-1:0] cnt_mask_t;

    // Data-phase state, same encoding as HTRANS
    typedef enum logic [1:0] {
        ST_IDLE   = 2'b00,
        ST_BUSY   = 2'b01,
        ST_NONSEQ = 2'b10,
        ST_SEQ    = 2'b11
    } slave_state_e;

endpackage

// ==== common/pmu_reg_if.sv ====
// Register access channel from the AHB slave to the register bank.
// The slave side presents a decoded index and a one-cycle write strobe;
// the bank side answers with read data for the same index.

`include "pmu_config.svh"

interface pmu_reg_if;

    // Write strobe, high only in the data phase of an accepted write
    logic                wr_stb;
    // Word index of the current data phase
    pmu_pkg::reg_idx_t   idx;
    // Index lies inside the register map
    logic                idx_valid;
    pmu_pkg::reg_word_t  wdata;
    // Read data, combinational from idx
    pmu_pkg::reg_word_t  rdata;

    modport slave (
        output wr_stb, idx, idx_valid, wdata,
        input  rdata
    );

    modport bank (
        input  wr_stb, idx, idx_valid, wdata,
        output rdata
    );

endinterface

// ==== common/pmu_cnt_if.sv ====
// Control and result channel of one event counter.
// The register logic drives the commands, the counter returns its value
// and overflow pulse, and the status unit observes both results.

`include "pmu_config.svh"

interface pmu_cnt_if;

    // Commands, priority clr over load over inc
    logic                inc;
    logic                clr;
    logic                load;
    pmu_pkg::reg_word_t  load_data;

    // Results
    pmu_pkg::reg_word_t  value;
    // One-cycle pulse after a wrap
    logic                ovf;

    modport ctrl (output inc, clr, load, load_data);

    modport cnt (
        input  inc, clr, load, load_data,
        output value, ovf
    );

    modport stat (input value, ovf);

endinterface

// ==== design/pmu_ahb/pmu_ahb_slave.sv ====
// AHB-lite slave front end of the PMU.
// Captures the address phase and decodes the following data phase into a
// register index and a one-cycle write strobe. Zero wait states, no
// error response; IDLE, BUSY or a deselected slave never write.

`include "pmu_config.svh"

module pmu_ahb_slave (
    input  logic                       clk_i,
    input  logic                       rstn_i,
    input  logic                       hsel_i,
    input  logic [1:0]                 htrans_i,
    input  logic                       hwrite_i,
    input  logic [`PMU_ADDR_WIDTH-1:0] haddr_i,
    input  pmu_pkg::reg_word_t         hwdata_i,
    pmu_reg_if.slave                   reg_o
);

    // ------------------------------------------------------------------
    // Address phase capture
    // ------------------------------------------------------------------

    pmu_pkg::slave_state_e       state_d;
    pmu_pkg::slave_state_e       state_q;
    logic                        write_q;
    logic [`PMU_ADDR_WIDTH-1:0]  addr_q;

    // Deselected slave sees the transfer as IDLE
    always_comb begin
        if (hsel_i) begin
            state_d = pmu_pkg::slave_state_e'(htrans_i);
        end else begin
            state_d = pmu_pkg::ST_IDLE;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q <= pmu_pkg::ST_IDLE;
            write_q <= 1'b0;
            addr_q  <= '0;
        end else begin
            state_q <= state_d;
            // Only real transfers carry a direction and an address
            if (state_d == pmu_pkg::ST_NONSEQ || state_d == pmu_pkg::ST_SEQ) begin
                write_q <= hwrite_i;
                addr_q  <= haddr_i;
            end
        end
    end

    // ------------------------------------------------------------------
    // Data phase decode
    // ------------------------------------------------------------------

    logic active;

    // Data phase of a NONSEQ or SEQ transfer
    assign active = (state_q == pmu_pkg::ST_NONSEQ) || (state_q == pmu_pkg::ST_SEQ);

    // Word index from byte address
    assign reg_o.idx       = addr_q[`PMU_IDX_WIDTH+1:2];
    assign reg_o.idx_valid = (reg_o.idx < pmu_pkg::reg_idx_t'(`PMU_N_REGS));

    // Write data belongs to this cycle, lands at its closing edge
    assign reg_o.wdata  = hwdata_i;
    assign reg_o.wr_stb = active && write_q && reg_o.idx_valid;

endmodule

// ==== design/pmu_ctrl_regs.sv ====
// Control, mask and event-select registers of the PMU.
// Also holds the event crossbar, which routes one system event to each
// counter, and steers bus writes into counter load and clear commands.
// All commands are combinational and act at the edge ending the data phase.

`include "pmu_config.svh"

module pmu_ctrl_regs (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  pmu_pkg::events_t     events_i,
    pmu_reg_if.bank              reg_i,
    pmu_cnt_if.ctrl              cnt_o [`PMU_N_COUNTERS],
    output logic                 enable_o,
    output pmu_pkg::cnt_mask_t   mask_o,
    output pmu_pkg::event_sel_t  sel_o [`PMU_N_COUNTERS]
);

    // ------------------------------------------------------------------
    // Register bank
    // ------------------------------------------------------------------

    logic                 enable_q;
    pmu_pkg::cnt_mask_t   mask_q;
    pmu_pkg::event_sel_t  sel_q [`PMU_N_COUNTERS];
    logic                 ctrl_wr;
    logic                 mask_wr;

    assign ctrl_wr = reg_i.wr_stb && (reg_i.idx == pmu_pkg::reg_idx_t'(`PMU_REG_CTRL));
    assign mask_wr = reg_i.wr_stb && (reg_i.idx == pmu_pkg::reg_idx_t'(`PMU_REG_OVF_MASK));

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            enable_q <= 1'b0;
            mask_q   <= '0;
            for (int k = 0; k < `PMU_N_COUNTERS; k++) begin
                sel_q[k] <= '0;
            end
        end else begin
            // Clear bit is a command only, never stored
            if (ctrl_wr) begin
                enable_q <= reg_i.wdata[`PMU_CTRL_EN_BIT];
            end
            if (mask_wr) begin
                mask_q <= reg_i.wdata[`PMU_N_COUNTERS-1:0];
            end
            // Select registers keep the low event-number bits only
            for (int k = 0; k < `PMU_N_COUNTERS; k++) begin
                if (reg_i.wr_stb &&
                    reg_i.idx == pmu_pkg::reg_idx_t'(`PMU_REG_SEL_BASE + k)) begin
                    sel_q[k] <= reg_i.wdata[`PMU_SEL_WIDTH-1:0];
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // Crossbar and counter commands
    // ------------------------------------------------------------------

    logic clr_all;

    // Clear hits every counter at once
    assign clr_all = ctrl_wr && reg_i.wdata[`PMU_CTRL_CLR_BIT];

    for (genvar i = 0; i < `PMU_N_COUNTERS; i++) begin : g_cnt_cmd
        // Selected event, counted only while enabled
        assign cnt_o[i].inc       = enable_q && events_i[sel_q[i]];
        assign cnt_o[i].clr       = clr_all;
        // Direct counter write through the bus
        assign cnt_o[i].load      = reg_i.wr_stb &&
                                    (reg_i.idx == pmu_pkg::reg_idx_t'(`PMU_REG_CNT_BASE + i));
        assign cnt_o[i].load_data = reg_i.wdata;
        assign sel_o[i]           = sel_q[i];
    end

    // Readback for the status unit
    assign enable_o = enable_q;
    assign mask_o   = mask_q;

endmodule

// ==== design/pmu_counter.sv ====
// One 32-bit event counter.
// Clear wins over load, load wins over increment. A wrap from all ones
// to zero gives a one-cycle overflow pulse in the following cycle.

`include "pmu_config.svh"

module pmu_counter (
    input  logic     clk_i,
    input  logic     rstn_i,
    pmu_cnt_if.cnt   cnt_i
);

    pmu_pkg::reg_word_t  value_q;
    logic                ovf_q;
    logic                wrap;

    // Increment is the only action that can wrap
    assign wrap = cnt_i.inc && !cnt_i.clr && !cnt_i.load && (value_q == '1);

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            value_q <= '0;
        end else if (cnt_i.clr) begin
            value_q <= '0;
        end else if (cnt_i.load) begin
            value_q <= cnt_i.load_data;
        end else if (cnt_i.inc) begin
            // Wraps naturally to zero
            value_q <= value_q + 1'b1;
        end
    end

    // Overflow pulse, one cycle behind the wrapping edge
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            ovf_q <= 1'b0;
        end else begin
            ovf_q <= wrap;
        end
    end

    assign cnt_i.value = value_q;
    assign cnt_i.ovf   = ovf_q;

endmodule

// ==== design/pmu_status_unit.sv ====
// Overflow status, overflow interrupt and read-data multiplexer.
// Status bits are sticky and cleared by writing 1; a set wins over a
// clear in the same cycle. The interrupt is registered from status and
// mask. Reads of an index outside the map return zero.

`include "pmu_config.svh"

module pmu_status_unit (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    pmu_reg_if.bank              reg_i,
    pmu_cnt_if.stat              cnt_i [`PMU_N_COUNTERS],
    input  logic                 enable_i,
    input  pmu_pkg::cnt_mask_t   mask_i,
    input  pmu_pkg::event_sel_t  sel_i [`PMU_N_COUNTERS],
    output logic                 intr_overflow_o
);

    pmu_pkg::reg_word_t  value [`PMU_N_COUNTERS];
    pmu_pkg::cnt_mask_t  ovf_vec;
    pmu_pkg::cnt_mask_t  status_q;
    pmu_pkg::cnt_mask_t  clr_bits;
    pmu_pkg::reg_word_t  rd_word;
    logic                intr_q;

    // Flatten the counter results so they can be indexed
    for (genvar i = 0; i < `PMU_N_COUNTERS; i++) begin : g_cnt_res
        assign value[i]   = cnt_i[i].value;
        assign ovf_vec[i] = cnt_i[i].ovf;
    end

    // ------------------------------------------------------------------
    // Sticky status and interrupt
    // ------------------------------------------------------------------

    // Write-1-to-clear
    assign clr_bits = (reg_i.wr_stb &&
                       reg_i.idx == pmu_pkg::reg_idx_t'(`PMU_REG_OVF_STATUS)) ?
                      reg_i.wdata[`PMU_N_COUNTERS-1:0] : '0;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            status_q <= '0;
            intr_q   <= 1'b0;
        end else begin
            status_q <= (status_q & ~clr_bits) | ovf_vec;
            // Follows the stored status one cycle later
            intr_q   <= |(status_q & mask_i);
        end
    end

    assign intr_overflow_o = intr_q;

    // ------------------------------------------------------------------
    // Read multiplexer
    // ------------------------------------------------------------------

    always_comb begin
        rd_word = '0;
        // Clear bit always reads as zero
        if (reg_i.idx == pmu_pkg::reg_idx_t'(`PMU_REG_CTRL)) begin
            rd_word[`PMU_CTRL_EN_BIT] = enable_i;
        end
        if (reg_i.idx == pmu_pkg::reg_idx_t'(`PMU_REG_OVF_STATUS)) begin
            rd_word = pmu_pkg::reg_word_t'(status_q);
        end
        if (reg_i.idx == pmu_pkg::reg_idx_t'(`PMU_REG_OVF_MASK)) begin
            rd_word = pmu_pkg::reg_word_t'(mask_i);
        end
        for (int k = 0; k < `PMU_N_COUNTERS; k++) begin
            if (reg_i.idx == pmu_pkg::reg_idx_t'(`PMU_REG_CNT_BASE + k)) begin
                rd_word = value[k];
            end
            if (reg_i.idx == pmu_pkg::reg_idx_t'(`PMU_REG_SEL_BASE + k)) begin
                rd_word = pmu_pkg::reg_word_t'(sel_i[k]);
            end
        end
    end

    // Holes above the map read as zero
    assign reg_i.rdata = reg_i.idx_valid ? rd_word : '0;

endmodule

// ==== design/pmu_ahb_top.sv ====
// Top level of the AHB-lite performance monitoring unit.
// Plain AHB slave ports plus the event inputs and the overflow interrupt.
// Transfers always complete in zero wait states with an OKAY response;
// size, burst, protection and lock inputs are accepted but not used.

`include "pmu_config.svh"

module pmu_ahb_top (
    input  logic                       rstn_i,
    input  logic                       clk_i,
    // AHB-lite slave port
    input  logic                       hsel_i,
    input  logic                       hreadyi_i,
    input  logic [`PMU_ADDR_WIDTH-1:0] haddr_i,
    input  logic                       hwrite_i,
    input  logic [1:0]                 htrans_i,
    input  logic [2:0]                 hsize_i,
    input  logic [2:0]                 hburst_i,
    input  pmu_pkg::reg_word_t         hwdata_i,
    input  logic [3:0]                 hprot_i,
    input  logic                       hmastlock_i,
    output logic                       hreadyo_o,
    output logic [1:0]                 hresp_o,
    output pmu_pkg::reg_word_t         hrdata_o,
    // PMU side
    input  pmu_pkg::events_t           events_i,
    output logic                       intr_overflow_o
);

    localparam logic [1:0] HRESP_OKAY = 2'b00;

    pmu_reg_if            u_reg_if ();
    pmu_cnt_if            u_cnt_if [`PMU_N_COUNTERS] ();
    logic                 enable;
    pmu_pkg::cnt_mask_t   mask;
    pmu_pkg::event_sel_t  sel [`PMU_N_COUNTERS];

    // ------------------------------------------------------------------
    // Bus front end
    // ------------------------------------------------------------------

    pmu_ahb_slave u_pmu_ahb_slave (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .hsel_i   (hsel_i),
        .htrans_i (htrans_i),
        .hwrite_i (hwrite_i),
        .haddr_i  (haddr_i),
        .hwdata_i (hwdata_i),
        .reg_o    (u_reg_if)
    );

    // No wait states, no errors
    assign hreadyo_o = 1'b1;
    assign hresp_o   = HRESP_OKAY;
    assign hrdata_o  = u_reg_if.rdata;

    // ------------------------------------------------------------------
    // Register logic, counters and status
    // ------------------------------------------------------------------

    pmu_ctrl_regs u_pmu_ctrl_regs (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .events_i (events_i),
        .reg_i    (u_reg_if),
        .cnt_o    (u_cnt_if),
        .enable_o (enable),
        .mask_o   (mask),
        .sel_o    (sel)
    );

    for (genvar i = 0; i < `PMU_N_COUNTERS; i++) begin : g_counter
        pmu_counter u_pmu_counter (
            .clk_i  (clk_i),
            .rstn_i (rstn_i),
            .cnt_i  (u_cnt_if[i])
        );
    end

    pmu_status_unit u_pmu_status_unit (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .reg_i           (u_reg_if),
        .cnt_i           (u_cnt_if),
        .enable_i        (enable),
        .mask_i          (mask),
        .sel_i           (sel),
        .intr_overflow_o (intr_overflow_o)
    );

endmodule

// ==== bench/pmu_tb.sv ====
// Testbench of the AHB-lite performance monitoring unit.
// Drives register accesses over AHB, runs random events through the
// counters and compares every read with a shadow model of the register map.
// Built as the simulation top with the file list in the project root.

`include "pmu_config.svh"

module pmu_tb;

    timeunit 1ns;
    timeprecision 100ps;

    // About 300 cycles of tests, with a wide margin
    localparam int         TIMEOUT_CYCLES = 3000;
    localparam logic [1:0] HTRANS_IDLE    = 2'b00;
    localparam logic [1:0] HTRANS_NONSEQ  = 2'b10;

    logic                       clk_i;
    logic                       rstn_i;
    logic                       hsel_i;
    logic [`PMU_ADDR_WIDTH-1:0] haddr_i;
    logic                       hwrite_i;
    logic [1:0]                 htrans_i;
    pmu_pkg::reg_word_t         hwdata_i;
    pmu_pkg::reg_word_t         hrdata_o;
    logic                       hreadyo_o;
    logic [1:0]                 hresp_o;
    pmu_pkg::events_t           events_i;
    logic                       intr_overflow_o;

    integer seed;
    int     errors = 0;
    int     cycles = 0;
    // Shadow of every readable word, indexes above the map stay zero
    pmu_pkg::reg_word_t shadow [16];

    pmu_ahb_top u_pmu_ahb_top (
        .rstn_i          (rstn_i),
        .clk_i           (clk_i),
        .hsel_i          (hsel_i),
        .hreadyi_i       (1'b1),
        .haddr_i         (haddr_i),
        .hwrite_i        (hwrite_i),
        .htrans_i        (htrans_i),
        .hsize_i         (3'b010),
        .hburst_i        (3'b000),
        .hwdata_i        (hwdata_i),
        .hprot_i         (4'b0011),
        .hmastlock_i     (1'b0),
        .hreadyo_o       (hreadyo_o),
        .hresp_o         (hresp_o),
        .hrdata_o        (hrdata_o),
        .events_i        (events_i),
        .intr_overflow_o (intr_overflow_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failed");
            $finish;
        end
    end

    // ------------------------------------------------------------------
    // Checks and shadow model
    // ------------------------------------------------------------------

    task automatic check_equal(input string name, input pmu_pkg::reg_word_t exp,
                               input pmu_pkg::reg_word_t act);
        assert (act == exp)
        else begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    // Register rules of the map, applied to an accepted write
    function automatic void model_write(input int idx, input pmu_pkg::reg_word_t data);
        if (idx == `PMU_REG_CTRL) begin
            shadow[idx] = pmu_pkg::reg_word_t'(data[`PMU_CTRL_EN_BIT]);
            if (data[`PMU_CTRL_CLR_BIT]) begin
                for (int k = 0; k < `PMU_N_COUNTERS; k++) begin
                    shadow[`PMU_REG_CNT_BASE + k] = '0;
                end
            end
        end else if (idx >= `PMU_REG_CNT_BASE && idx < `PMU_REG_OVF_STATUS) begin
            shadow[idx] = data;
        end else if (idx == `PMU_REG_OVF_STATUS) begin
            // Write 1 to clear
            shadow[idx] = shadow[idx] & ~pmu_pkg::reg_word_t'(data[`PMU_N_COUNTERS-1:0]);
        end else if (idx == `PMU_REG_OVF_MASK) begin
            shadow[idx] = pmu_pkg::reg_word_t'(data[`PMU_N_COUNTERS-1:0]);
        end else if (idx >= `PMU_REG_SEL_BASE && idx < `PMU_N_REGS) begin
            shadow[idx] = pmu_pkg::reg_word_t'(data[`PMU_SEL_WIDTH-1:0]);
        end
    endfunction

    function automatic logic expected_intr();
        return |(shadow[`PMU_REG_OVF_STATUS] & shadow[`PMU_REG_OVF_MASK]);
    endfunction

    // ------------------------------------------------------------------
    // Bus and event tasks, all entered 1 ns after a rising edge
    // ------------------------------------------------------------------

    task automatic bus_write_raw(input logic sel, input logic [1:0] trans, input int idx,
                                 input pmu_pkg::reg_word_t data);
        hsel_i   = sel;
        htrans_i = trans;
        hwrite_i = 1'b1;
        haddr_i  = 32'(idx * 4);
        @(posedge clk_i);
        #1;
        // Data phase
        hsel_i   = 1'b0;
        htrans_i = HTRANS_IDLE;
        hwrite_i = 1'b0;
        hwdata_i = data;
        @(posedge clk_i);
        #1;
    endtask

    task automatic ahb_write(input int idx, input pmu_pkg::reg_word_t data);
        bus_write_raw(1'b1, HTRANS_NONSEQ, idx, data);
        model_write(idx, data);
    endtask

    task automatic ahb_read(input int idx, output pmu_pkg::reg_word_t data);
        hsel_i   = 1'b1;
        htrans_i = HTRANS_NONSEQ;
        hwrite_i = 1'b0;
        haddr_i  = 32'(idx * 4);
        @(posedge clk_i);
        #1;
        hsel_i   = 1'b0;
        htrans_i = HTRANS_IDLE;
        data     = hrdata_o;
        check_equal("hready high", 32'h1, pmu_pkg::reg_word_t'(hreadyo_o));
        check_equal("hresp okay", 32'h0, pmu_pkg::reg_word_t'(hresp_o));
        @(posedge clk_i);
        #1;
    endtask

    task automatic check_reg(input string name, input int idx);
        pmu_pkg::reg_word_t rd;
        ahb_read(idx, rd);
        check_equal($sformatf("%s reg %0d", name, idx), shadow[idx], rd);
    endtask

    // Every index the 4-bit decode can reach, holes included
    task automatic check_all_regs(input string name);
        for (int idx = 0; idx < 16; idx++) begin
            check_reg(name, idx);
        end
    endtask

    task automatic check_intr(input string name);
        check_equal(name, pmu_pkg::reg_word_t'(expected_intr()),
                    pmu_pkg::reg_word_t'(intr_overflow_o));
    endtask

    // One cycle of events, counted by the model at the closing edge
    task automatic drive_events(input pmu_pkg::events_t ev);
        int cnt;
        events_i = ev;
        if (shadow[`PMU_REG_CTRL][`PMU_CTRL_EN_BIT]) begin
            for (int k = 0; k < `PMU_N_COUNTERS; k++) begin
                cnt = `PMU_REG_CNT_BASE + k;
                if (ev[shadow[`PMU_REG_SEL_BASE + k][`PMU_SEL_WIDTH-1:0]]) begin
                    if (shadow[cnt] == '1) begin
                        shadow[`PMU_REG_OVF_STATUS][k] = 1'b1;
                    end
                    shadow[cnt] = shadow[cnt] + 1;
                end
            end
        end
        @(posedge clk_i);
        #1;
        events_i = '0;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk_i);
        #1;
    endtask

    // ------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------

    initial begin
        seed     = 32'h9025;
        rstn_i   = 1'b0;
        hsel_i   = 1'b0;
        haddr_i  = '0;
        hwrite_i = 1'b0;
        htrans_i = HTRANS_IDLE;
        hwdata_i = '0;
        events_i = '0;
        for (int idx = 0; idx < 16; idx++) begin
            shadow[idx] = '0;
        end
        repeat (8) @(posedge clk_i);
        #1;
        rstn_i = 1'b1;

        // Reset values
        check_all_regs("reset");
        check_intr("reset intr");

        // Random readback, then writes that must be ignored
        for (int k = 0; k < `PMU_N_COUNTERS; k++) begin
            ahb_write(`PMU_REG_CNT_BASE + k, $random(seed));
            ahb_write(`PMU_REG_SEL_BASE + k, $random(seed));
        end
        ahb_write(`PMU_REG_OVF_MASK, $random(seed));
        check_all_regs("readback");
        bus_write_raw(1'b1, HTRANS_NONSEQ, 12, $random(seed));
        bus_write_raw(1'b0, HTRANS_NONSEQ, `PMU_REG_CNT_BASE, $random(seed));
        // Inverted mask so a wrongly accepted write always shows
        bus_write_raw(1'b1, HTRANS_IDLE, `PMU_REG_OVF_MASK, ~shadow[`PMU_REG_OVF_MASK]);
        check_all_regs("ignored writes");

        // Counting random events with zeroed counters
        ahb_write(`PMU_REG_CTRL, 32'h2);
        for (int k = 0; k < `PMU_N_COUNTERS; k++) begin
            ahb_write(`PMU_REG_SEL_BASE + k, $random(seed));
        end
        ahb_write(`PMU_REG_CTRL, 32'h1);
        repeat (50) drive_events($random(seed));
        ahb_write(`PMU_REG_CTRL, 32'h0);
        check_all_regs("counting");

        // Overflow of counter 2 on event 5
        ahb_write(`PMU_REG_OVF_MASK, 32'h0);
        ahb_write(`PMU_REG_SEL_BASE + 2, 32'h5);
        ahb_write(`PMU_REG_CNT_BASE + 2, 32'hFFFF_FFFE);
        ahb_write(`PMU_REG_CTRL, 32'h1);
        repeat (2) begin
            drive_events(pmu_pkg::events_t'(1) << 5);
            drive_events('0);
        end
        wait_cycles(2);
        check_reg("overflow count", `PMU_REG_CNT_BASE + 2);
        check_reg("overflow status", `PMU_REG_OVF_STATUS);
        check_intr("intr masked off");
        ahb_write(`PMU_REG_OVF_MASK, 32'h4);
        wait_cycles(2);
        check_intr("intr masked on");
        ahb_write(`PMU_REG_OVF_STATUS, 32'h4);
        wait_cycles(2);
        check_intr("intr after status clear");
        check_reg("status clear", `PMU_REG_OVF_STATUS);

        // Global clear with enable kept set
        ahb_write(`PMU_REG_CTRL, 32'h3);
        check_all_regs("global clear");

        $display("Checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+common
common/pmu_pkg.sv
common/pmu_reg_if.sv
common/pmu_cnt_if.sv
design/pmu_ahb/pmu_ahb_slave.sv
design/pmu_ctrl_regs.sv
design/pmu_counter.sv
design/pmu_status_unit.sv
design/pmu_ahb_top.sv
bench/pmu_tb.sv

// ==== Makefile ====
# Verilator build and run of the PMU testbench

SOURCES := filelist.f common/pmu_config.svh $(shell grep -v '^+' filelist.f)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
obj_dir/Vpmu_tb: $(SOURCES)
	verilator --binary --timing --assert -j 0 --top-module pmu_tb \
		-f filelist.f -o Vpmu_tb

run: obj_dir/Vpmu_tb
	./obj_dir/Vpmu_tb | tee sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
